// ==== board_pkg.sv ====
`default_nettype none

package board_pkg;

  typedef logic [15:0] word_t;
  typedef logic [9:0]  prog_addr_t; // also the pc
  typedef logic [7:0]  data_addr_t;

  // two ff bytes close a program load
  localparam word_t LOAD_END_WORD = 16'hffff;

  // store here goes out on the uart
  localparam data_addr_t TX_PORT_ADDR = 8'd1;

endpackage

`default_nettype wire

// ==== cpu_dbg_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface cpu_dbg_if;
  isa_pkg::insn_t        insn;      // last executed instruction
  board_pkg::prog_addr_t pc;
  logic [5:0][7:0]       stack_low; // index 0 is top of stack
  logic                  halted;

  modport cpu (output insn, output pc, output stack_low, output halted);
  modport display (input insn, input pc, input stack_low, input halted);
endinterface

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  typedef enum logic [3:0] {
    OP_PUSH  = 4'h0, // push zero-extended immediate
    OP_ADD   = 4'h1,
    OP_SUB   = 4'h2, // second minus top
    OP_LOAD  = 4'h3,
    OP_STORE = 4'h4,
    OP_JMP   = 4'h5,
    OP_JZ    = 4'h6, // pops the tested entry
    OP_HALT  = 4'h7
  } opcode_t;

  typedef struct packed {
    opcode_t     op;
    logic [11:0] imm; // jumps use the low 10 bits
  } insn_imm_t;

  typedef struct packed {
    opcode_t    op;
    logic [3:0] unused;
    logic [7:0] addr; // data memory address
  } insn_mem_t;

  // PUSH/JMP/JZ read the imm view, LOAD/STORE the mem view
  typedef union packed {
    insn_imm_t imm;
    insn_mem_t mem;
  } insn_t;

  localparam int STACK_DEPTH = 16;

endpackage

`default_nettype wire

// ==== led_scan.sv ====
`timescale 1ns/10ps
`default_nettype none

module led_scan #(
  parameter int SCAN_PERIOD = 27000,
  parameter int GAP_ON      = 100,
  parameter int GAP_OFF     = 2000
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  cpu_dbg_if.display dbg,
  output logic [7:0] led_col,
  output logic [8:0] led_row
);

  localparam int CW = $clog2(SCAN_PERIOD + 1);

  logic [CW-1:0] counter; // dwell time in the current row
  logic [3:0]    row_idx;
  logic          row_on;
  logic [6:0]    seg;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      counter <= '0;
      row_idx <= '0;
    end else if (counter >= CW'(SCAN_PERIOD - 1)) begin
      counter <= '0;
      row_idx <= (row_idx == 4'd8) ? 4'd0 : row_idx + 4'd1;
    end else begin
      counter <= counter + 1'b1;
    end
  end

  // blank edges of each slot so neighbours don't ghost
  assign row_on  = (counter >= CW'(GAP_ON)) && (counter < CW'(SCAN_PERIOD - GAP_OFF));
  assign led_row = row_on ? (9'd1 << row_idx) : 9'd0;

  // segments a..g msb first
  always_comb begin
    case (dbg.pc[3:0])
      4'h0: seg = 7'b1111110;
      4'h1: seg = 7'b0110000;
      4'h2: seg = 7'b1101101;
      4'h3: seg = 7'b1111001;
      4'h4: seg = 7'b0110011;
      4'h5: seg = 7'b1011011;
      4'h6: seg = 7'b1011111;
      4'h7: seg = 7'b1110010;
      4'h8: seg = 7'b1111111;
      4'h9: seg = 7'b1111011;
      4'ha: seg = 7'b1110111;
      4'hb: seg = 7'b0011111;
      4'hc: seg = 7'b1001110;
      4'hd: seg = 7'b0111101;
      4'he: seg = 7'b1001111;
      default: seg = 7'b1000111;
    endcase
  end

  always_comb begin
    case (row_idx)
      4'd0: led_col = dbg.insn[15:8];
      4'd1: led_col = dbg.insn[7:0];
      4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7: led_col = dbg.stack_low[row_idx - 4'd2];
      4'd8: led_col = {seg, dbg.halted}; // dp marks halt
      default: led_col = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

// ==== prog_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module prog_loader (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  logic                  rx_valid,
  input  logic [7:0]            rx_byte,
  output logic                  wr_en,
  output board_pkg::prog_addr_t wr_addr,
  output board_pkg::word_t      wr_data,
  output logic                  run
);

  logic             phase;   // 1 while waiting for the low byte
  board_pkg::word_t byte_sr; // last two bytes
  board_pkg::word_t joined;
  logic             low_done, end_word;

  assign joined   = {byte_sr[7:0], rx_byte};
  assign low_done = rx_valid && phase;
  assign end_word = (joined == board_pkg::LOAD_END_WORD);
  assign wr_data  = byte_sr; // holds {hi, lo} during the wr_en cycle

  always_ff @(posedge sys_clk) begin
    if (rx_valid) byte_sr <= joined;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase   <= 1'b0;
      wr_en   <= 1'b0;
      wr_addr <= '0;
      run     <= 1'b0;
    end else begin
      wr_en <= low_done && !end_word;
      if (rx_valid) phase <= !phase;
      if (wr_en) wr_addr <= wr_addr + 1'b1;
      else if (low_done && end_word) wr_addr <= '0;
      if (rx_valid && run) run <= 1'b0; // new load begins
      else if (low_done && end_word) run <= 1'b1;
    end
  end

  // end word starts the cpu from address 0 and is never written
  a_no_end_write: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (low_done && end_word) |=> (!wr_en && run && wr_addr == '0))
    else $error("prog_loader: end word was written or did not start the cpu");

endmodule

`default_nettype wire

// ==== prog_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module prog_mem (
  input  logic                  sys_clk,
  input  logic                  wr_en,
  input  board_pkg::prog_addr_t wr_addr,
  input  board_pkg::prog_addr_t rd_addr,
  input  board_pkg::word_t      wr_data,
  output board_pkg::word_t      rd_data
);

  localparam int DEPTH = 2 ** $bits(board_pkg::prog_addr_t);

  board_pkg::word_t mem [DEPTH];

  always_ff @(posedge sys_clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
    rd_data <= mem[rd_addr]; // one cycle read latency
  end

endmodule

`default_nettype wire

// ==== stack_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module stack_cpu #(
  parameter int TX_DEPTH = 4
) (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  logic                  run,
  input  board_pkg::word_t      insn_word,
  output board_pkg::prog_addr_t pc,
  output logic                  tx_push,
  output logic [7:0]            tx_byte,
  input  logic                  credit_return,
  cpu_dbg_if.cpu                dbg
);

  localparam int DEPTH = isa_pkg::STACK_DEPTH;
  localparam int SP_W  = $clog2(DEPTH + 1);
  localparam int CR_W  = $clog2(TX_DEPTH + 1);

  isa_pkg::insn_t        insn, insn_q;
  isa_pkg::opcode_t      op;
  board_pkg::word_t      stack [DEPTH]; // entry 0 is top
  board_pkg::word_t      dmem [2 ** $bits(board_pkg::data_addr_t)];
  board_pkg::word_t      alu, push_val;
  board_pkg::data_addr_t daddr;
  board_pkg::prog_addr_t target;
  logic [SP_W-1:0]       sp; // number of live entries
  logic [CR_W-1:0]       credits;
  logic                  exec, halted, tx_store, fire;

  assign insn     = insn_word;
  assign op       = insn.imm.op;
  assign daddr    = insn.mem.addr;
  assign target   = insn.imm.imm[$bits(board_pkg::prog_addr_t)-1:0];
  assign tx_store = (op == isa_pkg::OP_STORE) && (daddr == board_pkg::TX_PORT_ADDR);
  // no credit, no execute: store repeats until one comes back
  assign fire     = run && exec && !halted && !(tx_store && credits == '0);
  assign alu      = (op == isa_pkg::OP_SUB) ? stack[1] - stack[0] : stack[1] + stack[0];
  assign push_val = (op == isa_pkg::OP_LOAD) ? dmem[daddr] : {4'h0, insn.imm.imm};

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      exec <= 1'b0;
      halted <= 1'b0;
      pc <= '0;
      sp <= '0;
      insn_q <= '0;
    end else if (!run) begin // loader holds us in reset
      exec <= 1'b0;
      halted <= 1'b0;
      pc <= '0;
      sp <= '0;
      insn_q <= '0;
    end else if (!exec && !halted) begin
      exec <= 1'b1; // fetch cycle, rd_data valid next
    end else if (fire) begin
      exec   <= 1'b0;
      insn_q <= insn;
      pc     <= pc + 1'b1;
      case (op)
        isa_pkg::OP_PUSH, isa_pkg::OP_LOAD: sp <= sp + 1'b1;
        isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_STORE: sp <= sp - 1'b1;
        isa_pkg::OP_JMP: pc <= target;
        isa_pkg::OP_JZ: begin
          sp <= sp - 1'b1;
          if (stack[0] == '0) pc <= target;
        end
        isa_pkg::OP_HALT: begin
          halted <= 1'b1;
          pc     <= pc; // frozen on the halt
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (fire) begin
      case (op)
        isa_pkg::OP_PUSH, isa_pkg::OP_LOAD: begin
          stack[0] <= push_val;
          for (int i = 1; i < DEPTH; i++) stack[i] <= stack[i-1];
        end
        isa_pkg::OP_ADD, isa_pkg::OP_SUB: begin
          stack[0] <= alu;
          for (int i = 1; i < DEPTH - 1; i++) stack[i] <= stack[i+1];
        end
        isa_pkg::OP_STORE, isa_pkg::OP_JZ: begin
          for (int i = 0; i < DEPTH - 1; i++) stack[i] <= stack[i+1];
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (fire && op == isa_pkg::OP_STORE) dmem[daddr] <= stack[0];
    if (fire && tx_store) tx_byte <= stack[0][7:0];
  end

  // credits outlive a reload, bytes may still sit in the tx fifo
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_push <= 1'b0;
      credits <= CR_W'(TX_DEPTH);
    end else begin
      tx_push <= fire && tx_store;
      credits <= credits - CR_W'(fire && tx_store) + CR_W'(credit_return);
    end
  end

  assign dbg.insn   = insn_q;
  assign dbg.pc     = pc;
  assign dbg.halted = halted;

  always_comb begin
    for (int i = 0; i < 6; i++) dbg.stack_low[i] = (sp > SP_W'(i)) ? stack[i][7:0] : 8'h00;
  end

  a_credit_max: assert property (@(posedge sys_clk) disable iff (!rst_n)
    credits <= CR_W'(TX_DEPTH))
    else $error("stack_cpu: credit count above tx fifo depth");

  a_sp_max: assert property (@(posedge sys_clk) disable iff (!rst_n)
    sp <= SP_W'(DEPTH))
    else $error("stack_cpu: stack overflow");

endmodule

`default_nettype wire

// ==== stack_trainer.f ====
board_pkg.sv
isa_pkg.sv
cpu_dbg_if.sv
uart_rx.sv
uart_tx.sv
prog_loader.sv
prog_mem.sv
stack_cpu.sv
led_scan.sv
stack_trainer_top.sv
stack_trainer_tb.sv

// ==== stack_trainer_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module stack_trainer_tb;

  localparam int  CLKS_PER_BIT = 8;
  localparam int  TX_DEPTH     = 2;
  localparam int  SCAN_PERIOD  = 40;
  localparam int  GAP_ON       = 2;
  localparam int  GAP_OFF      = 4;
  localparam int  FRAME_CYCLES = 10 * CLKS_PER_BIT;
  localparam int  LIT_CYCLES   = SCAN_PERIOD - GAP_ON - GAP_OFF;
  localparam int  GAP_CYCLES   = GAP_ON + GAP_OFF;
  // frames sent plus frames expected per test, countdown at its longest
  localparam int  TOTAL_FRAMES = (20 + 2) + (24 + 5) + (26 + 6) + (8 + 6) + (12 + 2);
  localparam time DRIVE_DLY    = 2;

  logic             sys_clk, rst_n, uart_rx, uart_tx;
  logic [7:0]       led_col;
  logic [8:0]       led_row;
  logic             loaded; // set once the first program is about to run
  logic [7:0]       tx_seen [$];
  logic [7:0]       exp_q [$];
  board_pkg::word_t prog [$];
  logic [7:0]       row_col [9]; // last column byte seen on each row
  int               lit_len, gap_len, cur_row;
  logic             row_seen;

  stack_trainer_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT), .TX_DEPTH(TX_DEPTH), .SCAN_PERIOD(SCAN_PERIOD),
    .GAP_ON(GAP_ON), .GAP_OFF(GAP_OFF)
  ) DUT (
    .sys_clk, .rst_n, .uart_rx, .uart_tx, .led_col, .led_row
  );

  initial begin : clock_gen
    sys_clk = 1'b0;
    forever #20 sys_clk = ~sys_clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else fail_run($sformatf("mismatch %s: got %0h expected %0h", name, got, exp));
  endtask

  function automatic board_pkg::word_t imm_insn(isa_pkg::opcode_t op, logic [11:0] imm);
    isa_pkg::insn_t w;
    w.imm.op  = op;
    w.imm.imm = imm;
    return w;
  endfunction

  function automatic board_pkg::word_t mem_insn(isa_pkg::opcode_t op, logic [7:0] addr);
    isa_pkg::insn_t w;
    w.mem.op     = op;
    w.mem.unused = 4'h0;
    w.mem.addr   = addr;
    return w;
  endfunction

  // one 8N1 frame, lsb first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge sys_clk);
      #DRIVE_DLY uart_rx = frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
    end
  endtask

  task automatic load_program();
    board_pkg::word_t end_word;
    end_word = board_pkg::LOAD_END_WORD;
    foreach (prog[i]) begin
      send_byte(prog[i][15:8]); // high byte first
      send_byte(prog[i][7:0]);
    end
    loaded = 1'b1;
    send_byte(end_word[15:8]);
    send_byte(end_word[7:0]);
  endtask

  // waits for the expected bytes, then a quiet line, then compares
  task automatic check_output();
    while (tx_seen.size() < exp_q.size()) @(posedge sys_clk);
    repeat (2 * FRAME_CYCLES) @(posedge sys_clk);
    check_value("uart_tx byte count", tx_seen.size(), exp_q.size());
    foreach (exp_q[i]) check_value($sformatf("uart_tx byte %0d", i), tx_seen[i], exp_q[i]);
    tx_seen.delete();
    exp_q.delete();
  endtask

  initial begin : tx_monitor
    logic [7:0] data;
    forever begin
      @(negedge sys_clk);
      if (rst_n && uart_tx === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge sys_clk); // middle of start bit
        assert (uart_tx === 1'b0) else fail_run("uart_tx start bit ended too early");
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge sys_clk);
          data[i] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
        assert (uart_tx === 1'b1) else fail_run("uart_tx frame has a low stop bit");
        tx_seen.push_back(data);
      end
    end
  end

  // row order, lit length and gap length of the scanner
  always @(negedge sys_clk) begin
    if (!rst_n) begin
      lit_len  = 0;
      gap_len  = 0;
      cur_row  = 8;
      row_seen = 1'b0;
    end else if (led_row == '0) begin
      if (lit_len != 0) check_value("led_row lit length", lit_len, LIT_CYCLES);
      lit_len = 0;
      gap_len++;
    end else begin
      if (lit_len == 0) begin
        if (row_seen) check_value("led_row gap length", gap_len, GAP_CYCLES);
        cur_row  = (cur_row + 1) % 9;
        row_seen = 1'b1;
        gap_len  = 0;
      end
      check_value("led_row", led_row, 9'd1 << cur_row);
      row_col[cur_row] = led_col;
      lit_len++;
    end
  end

  a_tx_idle: assert property (@(posedge sys_clk) disable iff (!rst_n) !loaded |-> uart_tx)
    else fail_run("uart_tx left idle before any program was loaded");

  a_row_onehot: assert property (@(posedge sys_clk) disable iff (!rst_n) $onehot0(led_row))
    else fail_run($sformatf("more than one led_row bit set: %h", led_row));

  initial begin : watchdog
    repeat (TOTAL_FRAMES * FRAME_CYCLES * 2) @(posedge sys_clk);
    fail_run("watchdog expired before the tests finished");
  end

  initial begin : main
    logic [11:0]      a, b;
    int               n;
    board_pkg::word_t halt_word, st_tx;
    void'($urandom(55867));
    uart_rx   = 1'b1;
    rst_n     = 1'b0;
    loaded    = 1'b0;
    halt_word = imm_insn(isa_pkg::OP_HALT, 12'h0a5); // imm ignored, shows on rows 0 and 1
    st_tx     = mem_insn(isa_pkg::OP_STORE, board_pkg::TX_PORT_ADDR);
    repeat (3) @(posedge sys_clk);
    #DRIVE_DLY rst_n = 1'b1;
    repeat (2 * FRAME_CYCLES) @(posedge sys_clk); // idle line before any load

    // sum then difference, sub is second minus top
    a    = 12'($urandom);
    b    = 12'($urandom);
    prog = {imm_insn(isa_pkg::OP_PUSH, a), imm_insn(isa_pkg::OP_PUSH, b),
            imm_insn(isa_pkg::OP_ADD, 12'h0), st_tx,
            imm_insn(isa_pkg::OP_PUSH, a), imm_insn(isa_pkg::OP_PUSH, b),
            imm_insn(isa_pkg::OP_SUB, 12'h0), st_tx, halt_word};
    exp_q = {8'(a + b), 8'(a - b)};
    load_program();
    check_output();

    // five stores in a row against two credits, stack order reverses them
    prog.delete();
    for (int i = 0; i < 5; i++) begin
      prog.push_back(imm_insn(isa_pkg::OP_PUSH, 12'h0a1 + 12'(i * 'h11)));
      exp_q.push_front(8'h0a1 + 8'(i * 'h11));
    end
    for (int i = 0; i < 5; i++) prog.push_back(st_tx);
    prog.push_back(halt_word);
    load_program();
    check_output();

    // countdown through data address 5
    n    = 1 + $urandom % 6;
    prog = {imm_insn(isa_pkg::OP_PUSH, 12'(n)), mem_insn(isa_pkg::OP_STORE, 8'd5),
            mem_insn(isa_pkg::OP_LOAD, 8'd5), st_tx, mem_insn(isa_pkg::OP_LOAD, 8'd5),
            imm_insn(isa_pkg::OP_PUSH, 12'd1), imm_insn(isa_pkg::OP_SUB, 12'h0),
            mem_insn(isa_pkg::OP_STORE, 8'd5), mem_insn(isa_pkg::OP_LOAD, 8'd5),
            imm_insn(isa_pkg::OP_JZ, 12'd11), imm_insn(isa_pkg::OP_JMP, 12'd2), halt_word};
    for (int k = n; k >= 1; k--) exp_q.push_back(8'(k));
    load_program();
    check_output();

    // endless sender, then a reload must cut it off
    prog = {imm_insn(isa_pkg::OP_PUSH, 12'h03c), st_tx, imm_insn(isa_pkg::OP_JMP, 12'd0)};
    load_program();
    while (tx_seen.size() < 3) @(posedge sys_clk);
    tx_seen.delete();
    prog = {imm_insn(isa_pkg::OP_PUSH, 12'h096), st_tx,
            imm_insn(isa_pkg::OP_PUSH, 12'h069), st_tx, halt_word};
    load_program();
    assert (tx_seen.size() <= TX_DEPTH + 2)
      else fail_run("old program kept sending after the reload began");
    foreach (tx_seen[i]) check_value($sformatf("old uart_tx byte %0d", i), tx_seen[i], 8'h3c);
    tx_seen.delete();
    exp_q = {8'h96, 8'h69};
    check_output();

    repeat (2 * 9 * SCAN_PERIOD) @(posedge sys_clk); // every row refreshed after halt
    check_value("row 0 led_col", row_col[0], halt_word[15:8]);
    check_value("row 1 led_col", row_col[1], halt_word[7:0]);
    assert (row_col[8][0] === 1'b1) else fail_run("decimal point on row 8 is off after HALT");

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== stack_trainer_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module stack_trainer_top #(
  parameter int CLKS_PER_BIT = 234,   // 27 MHz at 115200 baud
  parameter int TX_DEPTH     = 4,
  parameter int SCAN_PERIOD  = 27000, // 1 ms per row
  parameter int GAP_ON       = 100,
  parameter int GAP_OFF      = 2000
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       uart_rx,
  output logic       uart_tx,
  output logic [7:0] led_col,
  output logic [8:0] led_row
);

  logic [7:0]            rx_byte, tx_byte;
  logic                  rx_valid, wr_en, run, tx_push, credit_return;
  board_pkg::prog_addr_t wr_addr, pc;
  board_pkg::word_t      wr_data, insn_word;

  cpu_dbg_if dbg_bus ();

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .sys_clk, .rst_n, .rx(uart_rx), .rx_byte, .rx_valid
  );

  prog_loader u_loader (
    .sys_clk, .rst_n, .rx_valid, .rx_byte, .wr_en, .wr_addr, .wr_data, .run
  );

  prog_mem u_prog_mem (
    .sys_clk, .wr_en, .wr_addr, .rd_addr(pc), .wr_data, .rd_data(insn_word)
  );

  stack_cpu #(.TX_DEPTH(TX_DEPTH)) u_cpu (
    .sys_clk, .rst_n, .run, .insn_word, .pc, .tx_push, .tx_byte, .credit_return,
    .dbg(dbg_bus.cpu)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT), .TX_DEPTH(TX_DEPTH)) u_tx (
    .sys_clk, .rst_n, .tx_push, .tx_byte, .tx(uart_tx), .credit_return
  );

  led_scan #(.SCAN_PERIOD(SCAN_PERIOD), .GAP_ON(GAP_ON), .GAP_OFF(GAP_OFF)) u_scan (
    .sys_clk, .rst_n, .dbg(dbg_bus.display), .led_col, .led_row
  );

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 234
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  localparam int BW = $clog2(CLKS_PER_BIT);

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

  state_t        state;
  logic [1:0]    rx_sync; // line is async to sys_clk
  logic [BW-1:0] clk_cnt;
  logic [2:0]    bit_idx;
  logic [7:0]    shreg;

  assign rx_byte = shreg;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync  <= 2'b11;
      state    <= S_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_sync  <= {rx_sync[0], rx};
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          if (!rx_sync[1]) state <= S_START;
        end
        S_START: if (clk_cnt == BW'(CLKS_PER_BIT / 2 - 1)) begin
          clk_cnt <= '0;
          bit_idx <= '0;
          state   <= rx_sync[1] ? S_IDLE : S_DATA; // glitch, not a start bit
        end
        S_DATA: if (clk_cnt == BW'(CLKS_PER_BIT - 1)) begin
          clk_cnt <= '0;
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) state <= S_STOP;
        end
        default: if (clk_cnt == BW'(CLKS_PER_BIT - 1)) begin
          rx_valid <= rx_sync[1]; // framing check
          state    <= S_IDLE;
        end
      endcase
    end
  end

  // lsb first, sampled mid-bit
  always_ff @(posedge sys_clk) begin
    if (state == S_DATA && clk_cnt == BW'(CLKS_PER_BIT - 1)) shreg <= {rx_sync[1], shreg[7:1]};
  end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 234,
  parameter int TX_DEPTH     = 4
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       tx_push,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       credit_return
);

  localparam int PW = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
  localparam int CW = $clog2(TX_DEPTH + 1);
  localparam int BW = $clog2(CLKS_PER_BIT);

  logic [7:0]    fifo [TX_DEPTH];
  logic [PW-1:0] wr_ptr, rd_ptr;
  logic [CW-1:0] count;
  logic [9:0]    shreg; // stop, data, start
  logic [BW-1:0] clk_cnt;
  logic [3:0]    bit_cnt;
  logic          busy, load;

  assign load          = !busy && (count != '0);
  assign credit_return = load; // slot freed as byte moves to shifter
  assign tx            = shreg[0];

  always_ff @(posedge sys_clk) begin
    if (tx_push) fifo[wr_ptr] <= tx_byte;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      shreg   <= '1; // line idles high
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      count <= count + CW'(tx_push) - CW'(load);
      if (tx_push) wr_ptr <= (wr_ptr == PW'(TX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (load) begin
        rd_ptr  <= (rd_ptr == PW'(TX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        shreg   <= {1'b1, fifo[rd_ptr], 1'b0};
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= '0;
      end else if (busy) begin
        clk_cnt <= clk_cnt + 1'b1;
        if (clk_cnt == BW'(CLKS_PER_BIT - 1)) begin
          clk_cnt <= '0;
          shreg   <= {1'b1, shreg[9:1]};
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 4'd9) busy <= 1'b0; // stop bit done
        end
      end
    end
  end

  // holds only if the cpu keeps its credit count honest
  a_no_push_full: assert property (@(posedge sys_clk) disable iff (!rst_n)
    tx_push |-> (count < CW'(TX_DEPTH)))
    else $error("uart_tx: byte pushed into a full fifo");

endmodule

`default_nettype wire
